// ==== Bender.yml ====
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - cpu_if.sv
  - fetch_stage.sv
  - reg_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - cpu_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_cpu.sv

// ==== cpu_if.sv ====
interface dx_if;
    import cpu_pkg::*;

    addr_t  pc;  // fetch address plus one
    instr_t ir;
    word_t  a;   // rs value from the register file
    word_t  b;   // second source value

    modport src (
        output pc, ir, a, b
    );

    modport dst (
        input pc, ir, a, b
    );
endinterface

interface bypass_if;
    import cpu_pkg::*;

    instr_t xm_ir;
    word_t  xm_o;
    instr_t mw_ir;
    word_t  mw_wdata;  // writeback value
    logic   mw_we;

    modport xm (
        output xm_ir, xm_o
    );

    modport mw (
        output mw_ir, mw_wdata, mw_we
    );

    modport fwd (
        input xm_ir, xm_o, mw_ir, mw_wdata, mw_we
    );
endinterface

// ==== cpu_pkg.sv ====
package cpu_pkg;

    localparam int ADDR_W = 12;  // word address width of both memories

    typedef logic [31:0]       word_t;
    typedef logic [31:0]       instr_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [4:0]        reg_idx_t;
    typedef logic [4:0]        opcode_t;
    typedef logic [4:0]        alu_fn_t;

    localparam opcode_t OP_RTYPE = 5'd0;
    localparam opcode_t OP_J     = 5'd1;
    localparam opcode_t OP_BNE   = 5'd2;
    localparam opcode_t OP_JAL   = 5'd3;
    localparam opcode_t OP_JR    = 5'd4;
    localparam opcode_t OP_ADDI  = 5'd5;
    localparam opcode_t OP_BLT   = 5'd6;
    localparam opcode_t OP_SW    = 5'd7;
    localparam opcode_t OP_LW    = 5'd8;

    localparam alu_fn_t FN_ADD = 5'd0;
    localparam alu_fn_t FN_SUB = 5'd1;
    localparam alu_fn_t FN_AND = 5'd2;
    localparam alu_fn_t FN_OR  = 5'd3;
    localparam alu_fn_t FN_SLL = 5'd4;
    localparam alu_fn_t FN_SRA = 5'd5;

    localparam reg_idx_t LINK_REG = 5'd31;  // written by jal
    localparam instr_t   NOP      = '0;     // add r0, r0, r0

    function automatic opcode_t op_of(input instr_t ir);
        return ir[31:27];
    endfunction

    function automatic reg_idx_t rd_of(input instr_t ir);
        return ir[26:22];
    endfunction

    function automatic reg_idx_t rs_of(input instr_t ir);
        return ir[21:17];
    endfunction

    function automatic reg_idx_t rt_of(input instr_t ir);
        return ir[16:12];
    endfunction

    function automatic logic [4:0] shamt_of(input instr_t ir);
        return ir[11:7];
    endfunction

    function automatic alu_fn_t fn_of(input instr_t ir);
        return ir[6:2];
    endfunction

    function automatic word_t imm_of(input instr_t ir);
        return {{15{ir[16]}}, ir[16:0]};  // 17-bit signed immediate
    endfunction

    function automatic addr_t target_of(input instr_t ir);
        return ir[ADDR_W-1:0];  // only the low bits reach the memory
    endfunction

    // non R-type instructions read rd as their second source
    function automatic reg_idx_t src_b_of(input instr_t ir);
        return (op_of(ir) == OP_RTYPE) ? rt_of(ir) : rd_of(ir);
    endfunction

    function automatic reg_idx_t dest_of(input instr_t ir);
        case (op_of(ir))
            OP_JAL:                   return LINK_REG;
            OP_RTYPE, OP_ADDI, OP_LW: return rd_of(ir);
            default:                  return '0;  // no register write
        endcase
    endfunction

endpackage

// ==== cpu_top.sv ====
module cpu_top (
    input  logic            clock_i,
    input  logic            rst_n_i,
    output cpu_pkg::addr_t  imem_addr_o,
    input  cpu_pkg::instr_t imem_data_i,
    output cpu_pkg::addr_t  dmem_addr_o,
    output cpu_pkg::word_t  dmem_wdata_o,
    output logic            dmem_we_o,
    input  cpu_pkg::word_t  dmem_rdata_i
);
    import cpu_pkg::*;

    logic     stall;
    logic     do_jump;
    addr_t    jump_pc;
    addr_t    fd_pc;
    instr_t   fd_ir;
    reg_idx_t rf_raddr_a;
    reg_idx_t rf_raddr_b;
    word_t    rf_rdata_a;
    word_t    rf_rdata_b;
    reg_idx_t rf_waddr;
    word_t    xm_b;

    dx_if     dx_bus ();
    bypass_if byp_bus ();

    assign rf_waddr = dest_of(byp_bus.mw_ir);  // writeback target

    fetch_stage fetch_stage_inst (
        .clock_i     (clock_i),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall),
        .do_jump_i   (do_jump),
        .jump_pc_i   (jump_pc),
        .imem_data_i (imem_data_i),
        .imem_addr_o (imem_addr_o),
        .fd_pc_o     (fd_pc),
        .fd_ir_o     (fd_ir)
    );

    reg_file reg_file_inst (
        .clock_i   (clock_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rf_raddr_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .we_i      (byp_bus.mw_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (byp_bus.mw_wdata)
    );

    decode_stage decode_stage_inst (
        .clock_i      (clock_i),
        .rst_n_i      (rst_n_i),
        .fd_pc_i      (fd_pc),
        .fd_ir_i      (fd_ir),
        .flush_i      (do_jump),  // taken branch squashes DX
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_rdata_a_i (rf_rdata_a),
        .rf_rdata_b_i (rf_rdata_b),
        .stall_o      (stall),
        .dx           (dx_bus)
    );

    execute_stage execute_stage_inst (
        .clock_i   (clock_i),
        .rst_n_i   (rst_n_i),
        .dx        (dx_bus),
        .byp       (byp_bus),
        .xm        (byp_bus),
        .xm_b_o    (xm_b),
        .do_jump_o (do_jump),
        .jump_pc_o (jump_pc)
    );

    memory_stage memory_stage_inst (
        .clock_i      (clock_i),
        .rst_n_i      (rst_n_i),
        .xm_b_i       (xm_b),
        .byp          (byp_bus),
        .xm_ir_i      (byp_bus.xm_ir),
        .xm_o_i       (byp_bus.xm_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_rdata_i (dmem_rdata_i)
    );
endmodule

// ==== decode_stage.sv ====
module decode_stage (
    input  logic              clock_i,
    input  logic              rst_n_i,
    input  cpu_pkg::addr_t    fd_pc_i,
    input  cpu_pkg::instr_t   fd_ir_i,
    input  logic              flush_i,
    output cpu_pkg::reg_idx_t rf_raddr_a_o,
    output cpu_pkg::reg_idx_t rf_raddr_b_o,
    input  cpu_pkg::word_t    rf_rdata_a_i,
    input  cpu_pkg::word_t    rf_rdata_b_i,
    output logic              stall_o,
    dx_if.src                 dx
);
    import cpu_pkg::*;

    reg_idx_t src_a;
    reg_idx_t src_b;
    reg_idx_t load_dest;
    logic     dx_is_load;
    logic     hit_a;
    logic     hit_b;
    instr_t   dx_ir_q;
    addr_t    dx_pc_q;
    word_t    dx_a_q;
    word_t    dx_b_q;

    assign src_a = rs_of(fd_ir_i);
    assign src_b = src_b_of(fd_ir_i);

    assign rf_raddr_a_o = src_a;
    assign rf_raddr_b_o = src_b;

    // load in DX whose data is needed next cycle
    assign dx_is_load = (op_of(dx_ir_q) == OP_LW);
    assign load_dest  = dest_of(dx_ir_q);
    assign hit_a      = (src_a != '0) && (src_a == load_dest);
    assign hit_b      = (src_b != '0) && (src_b == load_dest)
                        && (op_of(fd_ir_i) != OP_SW);  // store data is bypassed later

    assign stall_o = dx_is_load && (hit_a || hit_b);

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            dx_ir_q <= NOP;
        end else if (stall_o || flush_i) begin
            dx_ir_q <= NOP;  // bubble
        end else begin
            dx_ir_q <= fd_ir_i;
        end
    end

    always_ff @(posedge clock_i) begin
        dx_pc_q <= fd_pc_i;
        dx_a_q  <= rf_rdata_a_i;
        dx_b_q  <= rf_rdata_b_i;
    end

    assign dx.pc = dx_pc_q;
    assign dx.ir = dx_ir_q;
    assign dx.a  = dx_a_q;
    assign dx.b  = dx_b_q;
endmodule

// ==== execute_stage.sv ====
module execute_stage (
    input  logic           clock_i,
    input  logic           rst_n_i,
    dx_if.dst              dx,
    bypass_if.fwd          byp,
    bypass_if.xm           xm,
    output cpu_pkg::word_t xm_b_o,
    output logic           do_jump_o,
    output cpu_pkg::addr_t jump_pc_o
);
    import cpu_pkg::*;

    reg_idx_t xm_dest;
    reg_idx_t mw_dest;
    word_t    op_a;      // rs after bypass
    word_t    op_b;      // rt or rd after bypass
    word_t    imm;
    word_t    result;
    opcode_t  op;
    logic     taken;
    instr_t   xm_ir_q;
    word_t    xm_o_q;
    word_t    xm_b_q;

    // XM wins over MW, both over the register file
    function automatic word_t fwd_val(input reg_idx_t src, input word_t reg_val,
                                      input reg_idx_t xm_dst, input word_t xm_val,
                                      input reg_idx_t mw_dst, input logic mw_we,
                                      input word_t mw_val);
        if (src != '0 && src == xm_dst) begin
            return xm_val;
        end else if (mw_we && src == mw_dst) begin
            return mw_val;
        end
        return reg_val;
    endfunction

    assign xm_dest = dest_of(byp.xm_ir);
    assign mw_dest = dest_of(byp.mw_ir);

    assign op_a = fwd_val(rs_of(dx.ir), dx.a, xm_dest, byp.xm_o,
                          mw_dest, byp.mw_we, byp.mw_wdata);
    assign op_b = fwd_val(src_b_of(dx.ir), dx.b, xm_dest, byp.xm_o,
                          mw_dest, byp.mw_we, byp.mw_wdata);

    assign op  = op_of(dx.ir);
    assign imm = imm_of(dx.ir);

    always_comb begin
        result = '0;
        case (op)
            OP_RTYPE: begin
                case (fn_of(dx.ir))
                    FN_ADD:  result = op_a + op_b;
                    FN_SUB:  result = op_a - op_b;
                    FN_AND:  result = op_a & op_b;
                    FN_OR:   result = op_a | op_b;
                    FN_SLL:  result = op_a << shamt_of(dx.ir);
                    FN_SRA:  result = word_t'($signed(op_a) >>> shamt_of(dx.ir));
                    default: result = '0;
                endcase
            end
            OP_ADDI, OP_SW, OP_LW: result = op_a + imm;  // sum or memory address
            OP_JAL:                result = {{(32 - ADDR_W){1'b0}}, dx.pc};  // link value
            default:               result = '0;
        endcase
    end

    // rd is compared against rs
    always_comb begin
        case (op)
            OP_BNE:              taken = (op_b != op_a);
            OP_BLT:              taken = ($signed(op_b) < $signed(op_a));
            OP_J, OP_JAL, OP_JR: taken = 1'b1;
            default:             taken = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            OP_BNE, OP_BLT: jump_pc_o = dx.pc + imm[ADDR_W-1:0];
            OP_JR:          jump_pc_o = op_b[ADDR_W-1:0];
            default:        jump_pc_o = target_of(dx.ir);
        endcase
    end

    assign do_jump_o = taken;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            xm_ir_q <= NOP;
        end else begin
            xm_ir_q <= dx.ir;
        end
    end

    always_ff @(posedge clock_i) begin
        xm_o_q <= result;
        xm_b_q <= op_b;  // store data
    end

    assign xm.xm_ir = xm_ir_q;
    assign xm.xm_o  = xm_o_q;
    assign xm_b_o   = xm_b_q;
endmodule

// ==== fetch_stage.sv ====
module fetch_stage (
    input  logic            clock_i,
    input  logic            rst_n_i,
    input  logic            stall_i,
    input  logic            do_jump_i,
    input  cpu_pkg::addr_t  jump_pc_i,
    input  cpu_pkg::instr_t imem_data_i,
    output cpu_pkg::addr_t  imem_addr_o,
    output cpu_pkg::addr_t  fd_pc_o,
    output cpu_pkg::instr_t fd_ir_o
);
    import cpu_pkg::*;

    addr_t  pc_q;
    addr_t  pc_plus1;
    instr_t fd_ir_q;
    addr_t  fd_pc_q;

    assign pc_plus1    = pc_q + addr_t'(1);
    assign imem_addr_o = pc_q;  // async instruction read

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            pc_q    <= '0;
            fd_ir_q <= NOP;
        end else if (do_jump_i) begin
            pc_q    <= jump_pc_i;
            fd_ir_q <= NOP;  // squash the wrong-path fetch
        end else if (!stall_i) begin
            pc_q    <= pc_plus1;
            fd_ir_q <= imem_data_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!stall_i || do_jump_i) begin
            fd_pc_q <= pc_plus1;  // return address / branch base
        end
    end

    assign fd_pc_o = fd_pc_q;
    assign fd_ir_o = fd_ir_q;
endmodule

// ==== memory_stage.sv ====
module memory_stage (
    input  logic            clock_i,
    input  logic            rst_n_i,
    input  cpu_pkg::word_t  xm_b_i,
    bypass_if.mw            byp,
    input  cpu_pkg::instr_t xm_ir_i,
    input  cpu_pkg::word_t  xm_o_i,
    output cpu_pkg::addr_t  dmem_addr_o,
    output cpu_pkg::word_t  dmem_wdata_o,
    output logic            dmem_we_o,
    input  cpu_pkg::word_t  dmem_rdata_i
);
    import cpu_pkg::*;

    instr_t mw_ir_q;
    word_t  mw_o_q;
    word_t  mw_d_q;   // load data
    word_t  wb_data;
    logic   wb_we;

    assign wb_we   = (dest_of(mw_ir_q) != '0);
    assign wb_data = (op_of(mw_ir_q) == OP_LW) ? mw_d_q : mw_o_q;

    assign dmem_addr_o = xm_o_i[ADDR_W-1:0];
    assign dmem_we_o   = (op_of(xm_ir_i) == OP_SW);

    // covers a load or ALU op right before the store
    assign dmem_wdata_o = (wb_we && dest_of(mw_ir_q) == src_b_of(xm_ir_i)) ? wb_data : xm_b_i;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            mw_ir_q <= NOP;
        end else begin
            mw_ir_q <= xm_ir_i;
        end
    end

    always_ff @(posedge clock_i) begin
        mw_o_q <= xm_o_i;
        mw_d_q <= dmem_rdata_i;
    end

    assign byp.mw_ir    = mw_ir_q;
    assign byp.mw_wdata = wb_data;
    assign byp.mw_we    = wb_we;
endmodule

// ==== reg_file.sv ====
module reg_file (
    input  logic              clock_i,
    input  logic              rst_n_i,
    input  cpu_pkg::reg_idx_t raddr_a_i,
    input  cpu_pkg::reg_idx_t raddr_b_i,
    output cpu_pkg::word_t    rdata_a_o,
    output cpu_pkg::word_t    rdata_b_o,
    input  logic              we_i,
    input  cpu_pkg::reg_idx_t waddr_i,
    input  cpu_pkg::word_t    wdata_i
);
    import cpu_pkg::*;

    word_t regs [1:31];  // r0 is not stored

    always_ff @(posedge clock_i) begin
        if (rst_n_i && we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write is seen by the reader
    assign rdata_a_o = (raddr_a_i == '0)                 ? '0      :
                       (we_i && waddr_i == raddr_a_i)    ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0)                 ? '0      :
                       (we_i && waddr_i == raddr_b_i)    ? wdata_i : regs[raddr_b_i];
endmodule

// ==== src.f ====
cpu_pkg.sv
cpu_if.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_clock_gen.sv
tb_cpu.sv

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clock_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clock_o = 1'b0;
        forever #20 clock_o = ~clock_o;  // 40 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clock_o);
        rst_n_o <= 1'b1;
    end
endmodule

// ==== tb_cpu.sv ====
module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    logic        clock;
    logic        gen_rst_n;
    logic        run_n;      // per-test reset request
    logic        rst_n;
    addr_t       imem_addr;
    instr_t      imem_data;
    addr_t       dmem_addr;
    word_t       dmem_wdata;
    logic        dmem_we;
    word_t       dmem_rdata;
    instr_t      imem [0:4095];
    word_t       dmem [0:4095];
    word_t       ref_mem [0:4095];
    instr_t      prog [$];
    addr_t       got_addr [$];
    word_t       got_data [$];
    addr_t       exp_addr [$];
    word_t       exp_data [$];
    logic [31:0] rng_state;
    int          checks;
    int          errors;
    int          timeouts;

    assign rst_n      = gen_rst_n & run_n;
    assign imem_data  = imem[imem_addr];  // async instruction read
    assign dmem_rdata = dmem[dmem_addr];

    tb_clock_gen tb_clock_gen_inst (
        .clock_o (clock),
        .rst_n_o (gen_rst_n)
    );

    cpu_top cpu_top_inst (
        .clock_i      (clock),
        .rst_n_i      (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_data_i  (imem_data),
        .dmem_addr_o  (dmem_addr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_we_o    (dmem_we),
        .dmem_rdata_i (dmem_rdata)
    );

    always @(posedge clock) begin
        if (rst_n === 1'b1 && dmem_we === 1'b1) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    // store monitor samples the settled port mid-cycle
    always @(negedge clock) begin
        if (rst_n === 1'b1 && dmem_we === 1'b1) begin
            got_addr.push_back(dmem_addr);
            got_data.push_back(dmem_wdata);
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic instr_t r_type(input alu_fn_t fn, input reg_idx_t rd, input reg_idx_t rs,
                                      input reg_idx_t rt, input logic [4:0] sh);
        return {OP_RTYPE, rd, rs, rt, sh, fn, 2'b00};
    endfunction

    function automatic instr_t i_type(input opcode_t op, input reg_idx_t rd, input reg_idx_t rs,
                                      input logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic instr_t j_type(input opcode_t op, input logic [26:0] tgt);
        return {op, tgt};
    endfunction

    function automatic word_t alu_ref(input alu_fn_t fn, input word_t x, input word_t y,
                                      input logic [4:0] sh);
        case (fn)
            FN_ADD:  return x + y;
            FN_SUB:  return x - y;
            FN_AND:  return x & y;
            FN_OR:   return x | y;
            FN_SLL:  return x << sh;
            FN_SRA:  return $signed(x) >>> sh;
            default: return '0;
        endcase
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_memories();
        int i;
        for (i = 0; i < 4096; i++) begin
            if (i < prog.size()) begin
                imem[i] = prog[i];
            end else begin
                imem[i] = j_type(OP_J, i);  // stray fetches spin in place
            end
            dmem[i]    = {addr_t'(i), 8'h5a, addr_t'(i)};
            ref_mem[i] = dmem[i];
        end
    endtask

    // sequential ISA model that steps one instruction at a time
    task automatic predict_stores();
        word_t  r [32];
        addr_t  pc;
        addr_t  next_pc;
        addr_t  ea;
        instr_t ir;
        word_t  a;
        word_t  d;
        word_t  imm;
        int     steps;
        logic   done;
        int     k;
        for (k = 0; k < 32; k++) begin
            r[k] = '0;
        end
        pc    = '0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 4000) begin
            ir      = imem[pc];
            a       = r[ir[21:17]];
            d       = r[ir[26:22]];  // rd value as store data or compare operand
            imm     = {{15{ir[16]}}, ir[16:0]};
            ea      = a[11:0] + imm[11:0];
            next_pc = pc + 1;
            case (ir[31:27])
                OP_RTYPE: r[ir[26:22]] = alu_ref(ir[6:2], a, r[ir[16:12]], ir[11:7]);
                OP_ADDI:  r[ir[26:22]] = a + imm;
                OP_LW:    r[ir[26:22]] = ref_mem[ea];
                OP_SW: begin
                    ref_mem[ea] = d;
                    exp_addr.push_back(ea);
                    exp_data.push_back(d);
                end
                OP_BNE: begin
                    if (d != a) begin
                        next_pc = pc + 1 + imm[11:0];
                    end
                end
                OP_BLT: begin
                    if ($signed(d) < $signed(a)) begin
                        next_pc = pc + 1 + imm[11:0];
                    end
                end
                OP_J: begin
                    next_pc = ir[11:0];
                    done    = (next_pc == pc);  // self-loop ends the program
                end
                OP_JAL: begin
                    r[31]   = word_t'(next_pc);
                    next_pc = ir[11:0];
                end
                OP_JR:   next_pc = d[11:0];
                default: ;
            endcase
            r[0]  = '0;
            pc    = next_pc;
            steps++;
        end
    endtask

    task automatic run_program(input string name);
        int cycles;
        int n;
        int i;
        @(posedge clock);
        run_n <= 1'b0;
        repeat (3) @(posedge clock);
        prog.push_back(j_type(OP_J, prog.size()));
        got_addr.delete();
        got_data.delete();
        exp_addr.delete();
        exp_data.delete();
        load_memories();
        predict_stores();
        cycles = 0;
        while (gen_rst_n !== 1'b1 && cycles < 100) begin
            @(posedge clock);
            cycles++;
        end
        if (gen_rst_n !== 1'b1) begin
            timeouts++;
            $display("%s: power-on reset never released", name);
        end
        @(posedge clock);
        run_n <= 1'b1;
        cycles = 0;
        while (got_addr.size() < exp_addr.size() && cycles < 1000) begin
            @(posedge clock);
            cycles++;
        end
        if (got_addr.size() < exp_addr.size()) begin
            timeouts++;
            $display("%s: timed out after %0d of %0d stores", name,
                     got_addr.size(), exp_addr.size());
        end
        repeat (12) @(posedge clock);  // late stores from a missed flush
        if (got_addr.size() != exp_addr.size()) begin
            errors++;
            $display("** Error at %0t: %s made %0d stores, expected %0d", $time, name,
                     got_addr.size(), exp_addr.size());
        end
        n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
        for (i = 0; i < n; i++) begin
            check_addr(got_addr[i], exp_addr[i], $sformatf("%s store %0d address", name, i));
            check_word(got_data[i], exp_data[i], $sformatf("%s store %0d data", name, i));
        end
    endtask

    task automatic chain_alu_results();
        int i;
        prog.delete();
        prog.push_back(i_type(OP_ADDI, 1, 0, 100));
        prog.push_back(i_type(OP_ADDI, 2, 0, 37));
        prog.push_back(r_type(FN_ADD, 3, 1, 2, 0));
        prog.push_back(r_type(FN_SUB, 4, 3, 1, 0));
        prog.push_back(r_type(FN_AND, 5, 4, 3, 0));
        prog.push_back(r_type(FN_OR, 6, 5, 2, 0));
        prog.push_back(r_type(FN_SLL, 7, 6, 0, 3));
        prog.push_back(r_type(FN_SUB, 8, 0, 7, 0));  // negative input for sra
        prog.push_back(r_type(FN_SRA, 9, 8, 0, 2));
        for (i = 3; i <= 9; i++) begin
            prog.push_back(i_type(OP_SW, i, 0, 16 + i));
        end
        run_program("alu chain");
    endtask

    task automatic sign_extend_immediates();
        prog.delete();
        prog.push_back(i_type(OP_ADDI, 1, 0, -5));
        prog.push_back(i_type(OP_ADDI, 2, 1, -65536));  // most negative immediate
        prog.push_back(i_type(OP_ADDI, 0, 0, 123));
        prog.push_back(r_type(FN_ADD, 0, 1, 1, 0));
        prog.push_back(i_type(OP_SW, 0, 0, 34));  // r0 right behind both writes to it
        prog.push_back(i_type(OP_SW, 1, 0, 32));
        prog.push_back(i_type(OP_SW, 2, 0, 33));
        prog.push_back(i_type(OP_SW, 2, 1, 40));  // base register is negative
        run_program("immediates");
    endtask

    task automatic stall_on_load_use();
        prog.delete();
        prog.push_back(i_type(OP_ADDI, 1, 0, 777));
        prog.push_back(i_type(OP_SW, 1, 0, 48));
        prog.push_back(i_type(OP_LW, 2, 0, 48));
        prog.push_back(r_type(FN_ADD, 3, 2, 1, 0));  // stalls one cycle
        prog.push_back(i_type(OP_SW, 3, 0, 49));
        prog.push_back(i_type(OP_ADDI, 6, 3, 5));
        prog.push_back(i_type(OP_SW, 6, 0, 50));
        prog.push_back(i_type(OP_LW, 7, 0, 49));
        prog.push_back(i_type(OP_SW, 7, 0, 51));     // load data straight into a store
        run_program("load use");
    endtask

    task automatic branch_and_flush();
        prog.delete();
        prog.push_back(i_type(OP_ADDI, 1, 0, -3));
        prog.push_back(i_type(OP_ADDI, 2, 0, 4));
        prog.push_back(i_type(OP_BNE, 1, 1, 5));   // equal operands fall through
        prog.push_back(i_type(OP_SW, 1, 0, 64));
        prog.push_back(i_type(OP_BLT, 2, 1, 3));   // 4 < -3 is false
        prog.push_back(i_type(OP_SW, 2, 0, 65));
        prog.push_back(i_type(OP_BLT, 1, 2, 2));   // taken to 9
        prog.push_back(i_type(OP_SW, 0, 0, 90));
        prog.push_back(i_type(OP_SW, 0, 0, 91));
        prog.push_back(i_type(OP_BNE, 1, 2, 2));   // taken to 12
        prog.push_back(i_type(OP_SW, 0, 0, 92));
        prog.push_back(i_type(OP_SW, 0, 0, 93));
        prog.push_back(i_type(OP_ADDI, 3, 0, 9));
        prog.push_back(i_type(OP_SW, 3, 0, 66));
        run_program("branches");
    endtask

    task automatic call_and_return();
        prog.delete();
        prog.push_back(i_type(OP_ADDI, 1, 0, 11));
        prog.push_back(j_type(OP_JAL, 6));
        prog.push_back(i_type(OP_SW, 1, 0, 81));    // return point
        prog.push_back(i_type(OP_ADDI, 4, 0, 7));
        prog.push_back(i_type(OP_SW, 4, 0, 82));
        prog.push_back(j_type(OP_J, 5));
        prog.push_back(i_type(OP_SW, LINK_REG, 0, 80));
        prog.push_back(i_type(OP_JR, LINK_REG, 0, 0));
        prog.push_back(i_type(OP_SW, 0, 0, 95));
        prog.push_back(i_type(OP_SW, 0, 0, 96));
        run_program("jal jr");
    endtask

    task automatic random_alu_program();
        int          i;
        logic [31:0] v;
        prog.delete();
        for (i = 1; i <= 8; i++) begin
            v = next_rand();
            prog.push_back(i_type(OP_ADDI, i, 0, v[16:0]));
        end
        for (i = 0; i < 24; i++) begin
            v = next_rand();
            prog.push_back(r_type(alu_fn_t'(v[2:0] % 6), reg_idx_t'(v[5:3] + 1),
                                  reg_idx_t'(v[9:6] % 9), reg_idx_t'(v[13:10] % 9), v[18:14]));
        end
        for (i = 1; i <= 8; i++) begin
            prog.push_back(i_type(OP_SW, i, 0, 100 + i));
        end
        run_program("random");
    endtask

    initial begin
        run_n     = 1'b0;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        rng_state = 32'hbf3a8fcf;
        prog.delete();
        load_memories();
        chain_alu_results();
        sign_extend_immediates();
        stall_on_load_use();
        branch_and_flush();
        call_and_return();
        random_alu_program();
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end
endmodule
